// File: vlog.f
design/sifhPkg.sv
design/histRam.sv
design/histCtrl.sv
design/peakFinder.sv
design/sifhTop.sv
verif/sifhTop_assertions.sv
verif/sifhTb.sv

// File: Bender.yml
package:
  name: sifh

sources:
  - design/sifhPkg.sv
  - design/histRam.sv
  - design/histCtrl.sv
  - design/peakFinder.sv
  - design/sifhTop.sv
  - target: test
    files:
      - verif/sifhTop_assertions.sv
      - verif/sifhTb.sv

// File: verif/sifhTb.sv
`default_nettype none

module sifhTb
    import sifhPkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] SEED = 32'hc3b50156;
    localparam int RAND_FRAMES = 6;
    localparam int SAT_EVENTS  = 300;
    // upper bound of all events sent by the test sequence below
    localparam int MAX_EVENTS  = RAND_FRAMES * 120 + SAT_EVENTS + 12 + 150 + 13 + 20;
    localparam int NUM_SCANS   = RAND_FRAMES + 7;
    localparam int CYCLE_LIMIT = MAX_EVENTS * 4 + NUM_SCANS * 40 + 200;

    logic        clk;
    logic        res;
    logic        wrEn;
    binIdx_t     data;
    logic        frameEnd;
    logic        busy;
    logic        peakValid;
    peakResult_t peak;

    int          model [NUM_BINS] = '{default: 0};  // expected bin counts
    logic [31:0] rngState;
    int          errors = 0;
    int          checks = 0;
    int          cycles;

    sifhTop dut_i (
        .clk       (clk),
        .res       (res),
        .wrEn      (wrEn),
        .data      (data),
        .frameEnd  (frameEnd),
        .busy      (busy),
        .peakValid (peakValid),
        .peak      (peak)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] nextRandom();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #2;                                   // drive point after the edge
    endtask

    task automatic waitIdle();
        while (busy !== 1'b0) begin
            nextCycle();
        end
    endtask

    task automatic sendEvent(input binIdx_t bin);
        waitIdle();
        wrEn = 1'b1;
        data = bin;
        nextCycle();
        wrEn = 1'b0;
        if (model[bin] < COUNT_MAX) begin
            model[bin]++;                     // saturating like the histogram
        end
    endtask

    // strobe frameEnd and expect the peak 34 cycles after the strobe cycle
    task automatic endFrame(input string name, input bit doCheck);
        int  b;
        int  n;
        int  expBin;
        int  expCount;
        bit  early;
        expBin   = 0;
        expCount = 0;
        early    = 1'b0;
        for (b = 0; b < NUM_BINS; b++) begin
            if (model[b] > expCount) begin   // strictly greater keeps the lower bin
                expBin   = b;
                expCount = model[b];
            end
            model[b] = 0;                     // scan leaves the RAM empty
        end
        waitIdle();
        frameEnd = 1'b1;
        nextCycle();
        frameEnd = 1'b0;
        for (n = 1; n <= NUM_BINS + 2; n++) begin
            @(negedge clk);
            if (n < NUM_BINS + 2 && peakValid === 1'b1) begin
                early = 1'b1;
            end
        end
        if (doCheck) begin
            if (early) begin
                errors++;
                $display("%s: peakValid came before cycle 34 after frameEnd", name);
            end
            if (peakValid !== 1'b1) begin
                errors++;
                $display("%s: peakValid missing 34 cycles after frameEnd", name);
            end else begin
                checkValue({name, " peak bin"}, expBin, peak.bin);
                checkValue({name, " peak count"}, expCount, peak.count);
                checkValue({name, " busy"}, 0, busy);
            end
        end
        nextCycle();
    endtask

    initial begin
        int f;
        int i;
        int nEvents;
        binIdx_t bin;
        res      = 1'b0;
        wrEn     = 1'b0;
        data     = '0;
        frameEnd = 1'b0;
        rngState = SEED;
        repeat (5) @(posedge clk);
        #2;
        res = 1'b1;

        checkValue("reset busy", 0, busy);
        checkValue("reset peakValid", 0, peakValid);
        checkValue("reset peak", 0, peak);
        endFrame("clearing scan", 1'b0);      // RAM starts unknown
        endFrame("empty frame", 1'b1);

        for (f = 0; f < RAND_FRAMES; f++) begin
            nEvents = 40 + int'(nextRandom() % 81);
            for (i = 0; i < nEvents; i++) begin
                sendEvent(binIdx_t'(nextRandom()));
            end
            endFrame($sformatf("random frame %0d", f), 1'b1);
        end

        bin = binIdx_t'(nextRandom());
        for (i = 0; i < SAT_EVENTS; i++) begin
            sendEvent(bin);
        end
        endFrame("saturation", 1'b1);

        for (i = 0; i < 6; i++) begin
            sendEvent(binIdx_t'(20));         // higher bin filled first
        end
        for (i = 0; i < 6; i++) begin
            sendEvent(binIdx_t'(7));
        end
        endFrame("tie", 1'b1);

        for (i = 0; i < 150; i++) begin
            sendEvent(binIdx_t'(3));
        end
        endFrame("heavy frame", 1'b1);
        for (i = 0; i < 9; i++) begin
            sendEvent(binIdx_t'(3));          // 159 if the scan left data behind
        end
        for (i = 0; i < 4; i++) begin
            sendEvent(binIdx_t'(30));
        end
        endFrame("after heavy frame", 1'b1);

        for (i = 0; i < 20; i++) begin
            sendEvent(binIdx_t'(14));
        end
        endFrame("back to back", 1'b1);

        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, dut_i.assertions_i.failCount);
        if (errors == 0 && dut_i.assertions_i.failCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/sifhTop_assertions.sv
`default_nettype none

// timing checks on the histogram controller and its RAM ports
module sifhTop_assertions
    import sifhPkg::*;
(
    input  logic    clk,
    input  logic    res,
    input  logic    wrEn,
    input  logic    busy,
    input  logic    peakValid,
    input  logic    rEn,
    input  binIdx_t raddr,
    input  histWr_t wr
);

    timeunit 1ns;
    timeprecision 1ps;

    int failCount = 0;                        // read by the testbench at the end

    quietInReset: assert property (@(posedge clk) !res |-> (!busy && !peakValid))
        else begin
            failCount++;
            $error("busy or peakValid is high while reset is asserted");
        end

    peakPulseOneCycle: assert property (@(posedge clk) disable iff (!res)
        peakValid |=> !peakValid)
        else begin
            failCount++;
            $error("peakValid stayed high for more than one cycle");
        end

    // accepted event is written back two edges later and not one
    updateWriteDelay: assert property (@(posedge clk) disable iff (!res)
        (wrEn && !busy) |=> !wr.en ##1 wr.en)
        else begin
            failCount++;
            $error("RAM write not exactly two cycles after an accepted event");
        end

    noSameBinAccess: assert property (@(posedge clk) disable iff (!res)
        (rEn && wr.en) |-> (raddr != wr.addr))
        else begin
            failCount++;
            $error("RAM read and write hit the same bin on one edge");
        end

endmodule

bind sifhTop sifhTop_assertions assertions_i (
    .clk       (clk),
    .res       (res),
    .wrEn      (wrEn),
    .busy      (busy),
    .peakValid (peakValid),
    .rEn       (rEn),
    .raddr     (raddr),
    .wr        (wr)
);

`default_nettype wire

// File: design/sifhTop.sv
`default_nettype none

// single-pixel photon timing histogram with peak search
module sifhTop
    import sifhPkg::*;
(
    input  logic        clk,
    input  logic        res,
    input  logic        wrEn,
    input  binIdx_t     data,
    input  logic        frameEnd,
    output logic        busy,
    output logic        peakValid,
    output peakResult_t peak
);

    logic    rEn;
    binIdx_t raddr;
    count_t  rdata;
    histWr_t wr;
    logic    scanStart;
    logic    scanValid;
    binIdx_t scanBin;
    logic    scanLast;

    histCtrl ctrl_i (
        .clk       (clk),
        .res       (res),
        .wrEn      (wrEn),
        .data      (data),
        .frameEnd  (frameEnd),
        .rdata     (rdata),
        .rEn       (rEn),
        .raddr     (raddr),
        .wr        (wr),
        .busy      (busy),
        .scanStart (scanStart),
        .scanValid (scanValid),
        .scanBin   (scanBin),
        .scanLast  (scanLast)
    );

    histRam ram_i (
        .clk   (clk),
        .wr    (wr),
        .rEn   (rEn),
        .raddr (raddr),
        .rdata (rdata)
    );

    // reads the scanned counts straight off the RAM port
    peakFinder finder_i (
        .clk       (clk),
        .res       (res),
        .scanStart (scanStart),
        .scanValid (scanValid),
        .scanBin   (scanBin),
        .scanLast  (scanLast),
        .rdata     (rdata),
        .peakValid (peakValid),
        .peak      (peak)
    );

endmodule

`default_nettype wire

// File: design/peakFinder.sv
`default_nettype none

// running maximum over the scanned counts
module peakFinder
    import sifhPkg::*;
(
    input  logic        clk,
    input  logic        res,
    input  logic        scanStart,
    input  logic        scanValid,
    input  binIdx_t     scanBin,
    input  logic        scanLast,
    input  count_t      rdata,
    output logic        peakValid,
    output peakResult_t peak
);

    peakResult_t best;                        // best bin so far in this scan
    peakResult_t cand;                        // best including the current bin

    // strictly greater, so ties keep the lower bin
    always_comb begin
        cand = best;
        if (scanValid && (rdata > best.count)) begin
            cand.bin   = scanBin;
            cand.count = rdata;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            best      <= '0;
            peak      <= '0;
            peakValid <= 1'b0;
        end else begin
            peakValid <= scanValid && scanLast;
            if (scanStart) begin
                best <= '0;                   // fresh search for this frame
            end else if (scanValid) begin
                best <= cand;
            end
            if (scanValid && scanLast) begin
                peak <= cand;                 // held until the next scan ends
            end
        end
    end

endmodule

`default_nettype wire

// File: design/histCtrl.sv
`default_nettype none

// sequences event read-modify-write and the end-of-frame scan/clear
module histCtrl
    import sifhPkg::*;
(
    input  logic    clk,
    input  logic    res,
    input  logic    wrEn,
    input  binIdx_t data,
    input  logic    frameEnd,
    input  count_t  rdata,
    output logic    rEn,
    output binIdx_t raddr,
    output histWr_t wr,
    output logic    busy,
    output logic    scanStart,
    output logic    scanValid,
    output binIdx_t scanBin,
    output logic    scanLast
);

    typedef enum logic [2:0] {
        IDLE,
        UPD_READ,
        UPD_WRITE,
        SCAN,
        SCAN_TAIL
    } ctrlState_t;

    ctrlState_t state;
    logic       scanValidQ;                   // rdata holds a scanned bin
    binIdx_t    scanBinQ;                     // raddr delayed by the RAM latency
    count_t     incCount;

    assign busy      = (state != IDLE);
    assign scanStart = (state == SCAN) && (raddr == '0);  // first read on the RAM port
    assign scanValid = scanValidQ;
    assign scanBin   = scanBinQ;
    assign scanLast  = scanValidQ && (scanBinQ == binIdx_t'(NUM_BINS - 1));

    // saturating increment of the returned count
    assign incCount = (rdata == COUNT_MAX) ? COUNT_MAX : rdata + count_t'(1);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state      <= IDLE;
            rEn        <= 1'b0;
            raddr      <= '0;
            scanValidQ <= 1'b0;
        end else begin
            scanValidQ <= (state == SCAN);    // one cycle behind each scan read
            case (state)
                IDLE: begin
                    if (wrEn) begin
                        rEn   <= 1'b1;
                        raddr <= data;        // raddr doubles as the event bin latch
                        state <= UPD_READ;
                    end else if (frameEnd) begin
                        rEn   <= 1'b1;
                        raddr <= '0;
                        state <= SCAN;
                    end
                end
                UPD_READ: begin
                    rEn   <= 1'b0;
                    state <= UPD_WRITE;       // count arrives next cycle
                end
                UPD_WRITE: begin
                    state <= IDLE;
                end
                SCAN: begin
                    if (raddr == binIdx_t'(NUM_BINS - 1)) begin
                        rEn   <= 1'b0;
                        state <= SCAN_TAIL;   // last count still in flight
                    end else begin
                        raddr <= raddr + binIdx_t'(1);
                    end
                end
                SCAN_TAIL: begin
                    state <= IDLE;
                end
                default: begin
                    rEn   <= 1'b0;
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        scanBinQ <= raddr;
    end

    // write port carries the updated count during an event and zero behind the scan
    always_comb begin
        wr = '0;
        case (state)
            UPD_WRITE: begin
                wr.en   = 1'b1;
                wr.addr = raddr;
                wr.data = incCount;
            end
            SCAN, SCAN_TAIL: begin
                wr.en   = scanValidQ;         // clear the bin just read out
                wr.addr = scanBinQ;
            end
            default: begin
                wr.en = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/histRam.sv
`default_nettype none

// simple dual-port histogram memory with registered read data
module histRam
    import sifhPkg::*;
(
    input  logic    clk,
    input  histWr_t wr,
    input  logic    rEn,
    input  binIdx_t raddr,
    output count_t  rdata
);

    count_t mem [NUM_BINS];                   // one count per time bin

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // same-address read and write on one edge returns the old count
    always_ff @(posedge clk) begin
        if (rEn) begin
            rdata <= mem[raddr];              // valid one cycle after rEn
        end
    end

endmodule

`default_nettype wire

// File: design/sifhPkg.sv
`default_nettype none

package sifhPkg;

    localparam int BIN_BITS   = 5;            // time-bin index width
    localparam int NUM_BINS   = 32;           // one counter per bin
    localparam int COUNT_BITS = 8;            // per-bin count width

    typedef logic [BIN_BITS-1:0]   binIdx_t;  // RAM address / bin number
    typedef logic [COUNT_BITS-1:0] count_t;   // photon count of one bin

    localparam count_t COUNT_MAX = '1;        // counts saturate here

    // write port of the histogram RAM
    typedef struct packed {
        logic    en;
        binIdx_t addr;
        count_t  data;
    } histWr_t;

    // peak of one frame
    typedef struct packed {
        binIdx_t bin;
        count_t  count;
    } peakResult_t;

endpackage

`default_nettype wire
